// ==== design/bp_settings.svh ====
// branch predictor settings

`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

////////////////////
// address and fetch
////////////////////

`define BP_XLEN        32            // address width
`define BP_INST_BYTES  4             // bytes per fetched instruction
`define BP_OFF_BITS    2             // byte offset below the index
`define BP_RESET_PC    32'h0000_1000 // first fetch address

////////////////////
// btb geometry
////////////////////

`define BP_BTB_LEN     16            // entries, power of two
`define BP_IDX_BITS    $clog2(`BP_BTB_LEN)

// tag is everything above index
`define BP_TAG_BITS    (`BP_XLEN - `BP_IDX_BITS - `BP_OFF_BITS)

`endif

// ==== design/bp_pkg.sv ====
// branch predictor types
`include "bp_settings.svh"

package bp_pkg;

    typedef logic [`BP_XLEN-1:0] bp_addr_t;

    // 2-bit saturating counter
    typedef enum logic [1:0] {
        nottake      = 2'b00,
        weak_nottake = 2'b01,
        weak_taken   = 2'b10,
        taken        = 2'b11
    } bp_counter_e;

    ////////////////////
    // btb storage and lookup
    ////////////////////

    typedef struct packed {
        logic                    busy;
        logic [`BP_TAG_BITS-1:0] tag;
        bp_addr_t                target_pc;
        bp_counter_e             state;
    } btb_entry_t;

    typedef struct packed {
        logic     hit;
        logic     prediction;  // taken or weak_taken
        bp_addr_t target_pc;
    } bp_lookup_t;

    ////////////////////
    // pipeline packets
    ////////////////////

    typedef struct packed {
        logic     valid;
        bp_addr_t pc;
        logic     pred_taken;
        bp_addr_t pred_target;
    } bp_fetch_t;

    typedef struct packed {
        logic     valid;
        bp_addr_t pc;
    } bp_decode_t;

    typedef struct packed {
        logic     valid;
        bp_addr_t pc;
        logic     taken;
        bp_addr_t target;
        logic     pred_taken;   // prediction carried down the pipe
        bp_addr_t pred_target;
    } bp_resolve_t;

    typedef struct packed {
        logic     valid;
        bp_addr_t pc;
        logic     taken;
        bp_addr_t target;
    } bp_train_t;

    typedef struct packed {
        logic     valid;
        bp_addr_t pc;
    } bp_redirect_t;

endpackage

// ==== design/btb.sv ====
// direct-mapped branch target buffer
`include "bp_settings.svh"

module btb (
    input  logic               clock,
    input  logic               reset,
    input  bp_pkg::bp_addr_t   lookup_pc,
    input  bp_pkg::bp_decode_t alloc,
    input  bp_pkg::bp_train_t  train,
    output bp_pkg::bp_lookup_t lookup
);

    localparam int IDX_LO = `BP_OFF_BITS;
    localparam int IDX_HI = `BP_OFF_BITS + `BP_IDX_BITS - 1;
    localparam int TAG_LO = IDX_HI + 1;

    typedef logic [`BP_IDX_BITS-1:0] idx_t;
    typedef logic [`BP_TAG_BITS-1:0] tag_t;

    bp_pkg::btb_entry_t entries      [`BP_BTB_LEN];
    bp_pkg::btb_entry_t next_entries [`BP_BTB_LEN];

    bp_pkg::btb_entry_t rd_entry;
    bp_pkg::btb_entry_t al_entry;
    bp_pkg::btb_entry_t tr_entry;
    logic               al_match;
    logic               tr_match;

    function automatic idx_t idx_of(input bp_pkg::bp_addr_t addr);
        return addr[IDX_HI:IDX_LO];
    endfunction

    function automatic tag_t tag_of(input bp_pkg::bp_addr_t addr);
        return addr[`BP_XLEN-1:TAG_LO];
    endfunction

    // one saturating step toward the outcome
    function automatic bp_pkg::bp_counter_e step(
        input bp_pkg::bp_counter_e cur,
        input logic                outcome
    );
        bp_pkg::bp_counter_e nxt;
        case (cur)
            bp_pkg::nottake:      nxt = outcome ? bp_pkg::weak_nottake : bp_pkg::nottake;
            bp_pkg::weak_nottake: nxt = outcome ? bp_pkg::weak_taken   : bp_pkg::nottake;
            bp_pkg::weak_taken:   nxt = outcome ? bp_pkg::taken        : bp_pkg::weak_nottake;
            default:              nxt = outcome ? bp_pkg::taken        : bp_pkg::weak_taken;
        endcase
        return nxt;
    endfunction

    ////////////////////
    // lookup
    ////////////////////

    assign rd_entry = entries[idx_of(lookup_pc)];

    always_comb begin
        lookup.hit        = rd_entry.busy && (rd_entry.tag == tag_of(lookup_pc));
        lookup.prediction = lookup.hit &&
                            ((rd_entry.state == bp_pkg::taken) ||
                             (rd_entry.state == bp_pkg::weak_taken));
        lookup.target_pc  = rd_entry.target_pc;
    end

    ////////////////////
    // allocate and train
    ////////////////////

    // both sides look at the entry as it was before this cycle
    assign al_entry = entries[idx_of(alloc.pc)];
    assign tr_entry = entries[idx_of(train.pc)];
    assign al_match = al_entry.busy && (al_entry.tag == tag_of(alloc.pc));
    assign tr_match = tr_entry.busy && (tr_entry.tag == tag_of(train.pc));

    always_comb begin
        next_entries = entries;
        if (alloc.valid && !al_match) begin
            next_entries[idx_of(alloc.pc)].busy      = 1'b1;
            next_entries[idx_of(alloc.pc)].tag       = tag_of(alloc.pc);
            next_entries[idx_of(alloc.pc)].target_pc = '0;
            next_entries[idx_of(alloc.pc)].state     = bp_pkg::nottake;
        end
        // train comes second so it wins on a shared index
        if (train.valid && tr_match) begin
            next_entries[idx_of(train.pc)].target_pc = train.target;
            next_entries[idx_of(train.pc)].state     = step(tr_entry.state, train.taken);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `BP_BTB_LEN; i++) begin
                entries[i].busy  <= 1'b0;
                entries[i].state <= bp_pkg::nottake;
            end
        end else begin
            entries <= next_entries;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    for (genvar i = 0; i < `BP_BTB_LEN; i++) begin : g_state_chk
        a_state_legal: assert property (@(posedge clock) disable iff (reset)
            !$isunknown(entries[i].state))
            else $error("btb entry %0d state illegal: %b", i, entries[i].state);
    end

endmodule

// ==== design/fetch_pc_gen.sv ====
// fetch address generator
`include "bp_settings.svh"

module fetch_pc_gen (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 stall,
    input  bp_pkg::bp_lookup_t   lookup,
    input  bp_pkg::bp_redirect_t redirect,
    output bp_pkg::bp_addr_t     lookup_pc,
    output bp_pkg::bp_fetch_t    fetch
);

    bp_pkg::bp_addr_t pc_q;
    bp_pkg::bp_addr_t pc_next;
    bp_pkg::bp_addr_t pc_seq;
    logic             valid_q;
    logic             pred_taken;

    assign pc_seq     = pc_q + bp_pkg::bp_addr_t'(`BP_INST_BYTES);
    assign pred_taken = lookup.hit && lookup.prediction;

    ////////////////////
    // next pc select
    ////////////////////

    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.pc;       // resolve correction beats stall
        end else if (stall || !valid_q) begin
            // hold, and keep the reset vector for the first valid fetch
            pc_next = pc_q;
        end else if (pred_taken) begin
            pc_next = lookup.target_pc;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q    <= `BP_RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            valid_q <= 1'b1;
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    assign lookup_pc = pc_q;  // btb answers in the same cycle

    always_comb begin
        fetch.valid       = valid_q;
        fetch.pc          = pc_q;
        fetch.pred_taken  = pred_taken;
        fetch.pred_target = pred_taken ? lookup.target_pc : pc_seq;
    end

    ////////////////////
    // checks
    ////////////////////

    // a bad btb target or redirect would show up here
    a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
        fetch.valid |-> ((fetch.pc % `BP_INST_BYTES) == 0))
        else $error("fetch pc misaligned: %h", fetch.pc);

endmodule

// ==== design/branch_resolve.sv ====
// branch resolve and redirect
`include "bp_settings.svh"

module branch_resolve (
    input  bp_pkg::bp_resolve_t  resolve,
    output bp_pkg::bp_train_t    train,
    output bp_pkg::bp_redirect_t redirect
);

    logic             dir_miss;
    logic             tgt_miss;
    logic             mispredict;
    bp_pkg::bp_addr_t fall_through;
    bp_pkg::bp_addr_t correct_pc;

    assign fall_through = resolve.pc + bp_pkg::bp_addr_t'(`BP_INST_BYTES);

    ////////////////////
    // prediction check
    ////////////////////

    always_comb begin
        // wrong direction
        dir_miss = resolve.taken != resolve.pred_taken;

        // right direction but wrong target, only matters when taken
        tgt_miss = resolve.taken && (resolve.target != resolve.pred_target);

        mispredict = resolve.valid && (dir_miss || tgt_miss);

        if (resolve.taken) begin
            correct_pc = resolve.target;
        end else begin
            correct_pc = fall_through;
        end
    end

    ////////////////////
    // btb training
    ////////////////////

    // every completed branch trains, the btb drops tag misses
    always_comb begin
        train.valid  = resolve.valid;
        train.pc     = resolve.pc;
        train.taken  = resolve.taken;
        train.target = resolve.target;
    end

    ////////////////////
    // fetch redirect
    ////////////////////

    always_comb begin
        redirect.valid = mispredict;
        redirect.pc    = correct_pc;  // steady even when not valid
    end

endmodule

// ==== design/branch_predict_top.sv ====
// branch prediction slice top

module branch_predict_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                stall,
    input  bp_pkg::bp_decode_t  decode,
    input  bp_pkg::bp_resolve_t resolve,
    output bp_pkg::bp_fetch_t   fetch
);

    bp_pkg::bp_addr_t     lookup_pc;
    bp_pkg::bp_lookup_t   lookup;
    bp_pkg::bp_train_t    train;
    bp_pkg::bp_redirect_t redirect;

    ////////////////////
    // fetch side
    ////////////////////

    fetch_pc_gen u_fetch_pc_gen (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .lookup    (lookup),
        .redirect  (redirect),
        .lookup_pc (lookup_pc),
        .fetch     (fetch)
    );

    ////////////////////
    // target buffer
    ////////////////////

    // decode allocates, resolve trains
    btb u_btb (
        .clock     (clock),
        .reset     (reset),
        .lookup_pc (lookup_pc),
        .alloc     (decode),
        .train     (train),
        .lookup    (lookup)
    );

    ////////////////////
    // resolve side
    ////////////////////

    branch_resolve u_branch_resolve (
        .resolve  (resolve),
        .train    (train),
        .redirect (redirect)
    );

endmodule

// ==== tb/branch_predict_tb.sv ====
// branch predictor testbench
`include "bp_settings.svh"

module branch_predict_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [`BP_TAG_BITS-1:0] tag_t;

    // one table row, expected fetch is the cycle after the row is applied
    typedef struct packed {
        int                  test;
        logic                stall;
        bp_pkg::bp_decode_t  decode;
        bp_pkg::bp_resolve_t resolve;
        bp_pkg::bp_addr_t    exp_pc;
        logic                exp_taken;
        bp_pkg::bp_addr_t    exp_target;
    } row_t;

    localparam bp_pkg::bp_addr_t BR_PC    = 32'h0000_1024;  // index 9
    localparam bp_pkg::bp_addr_t BR_TGT   = 32'h0000_2000;
    localparam bp_pkg::bp_addr_t CF_TGT   = 32'h0000_2400;
    localparam bp_pkg::bp_addr_t STEER_PC = 32'h0000_0ff0;  // never allocated
    localparam bp_pkg::bp_addr_t MP_PC    = 32'h0000_1100;
    localparam bp_pkg::bp_addr_t MP_TGT   = 32'h0000_3000;
    localparam bp_pkg::bp_addr_t NA_PC    = 32'h0000_5a5c;
    localparam bp_pkg::bp_addr_t NA_TGT   = 32'h0000_6000;
    localparam bp_pkg::bp_addr_t LOW_MASK = (1 << (`BP_OFF_BITS + `BP_IDX_BITS)) - 1;
    localparam bp_pkg::bp_addr_t IDX_MASK = (`BP_BTB_LEN - 1) << `BP_OFF_BITS;

    logic                clock = 1'b0;
    logic                reset;
    logic                stall;
    bp_pkg::bp_decode_t  decode;
    bp_pkg::bp_resolve_t resolve;
    bp_pkg::bp_fetch_t   fetch;

    row_t               rows [$];
    string              test_names [7];
    bp_pkg::btb_entry_t model_btb [`BP_BTB_LEN];
    bp_pkg::bp_addr_t   model_pc;
    int                 checks = 0;
    int                 errors = 0;
    int                 test_err = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;

    branch_predict_top u_dut (
        .clock   (clock),
        .reset   (reset),
        .stall   (stall),
        .decode  (decode),
        .resolve (resolve),
        .fetch   (fetch)
    );

    always #20 clock = ~clock;

    ////////////////////
    // reference model
    ////////////////////

    function automatic int index_of(input bp_pkg::bp_addr_t addr);
        return int'((addr >> `BP_OFF_BITS) % `BP_BTB_LEN);
    endfunction

    function automatic tag_t tag_of(input bp_pkg::bp_addr_t addr);
        return tag_t'(addr >> (`BP_OFF_BITS + `BP_IDX_BITS));
    endfunction

    function automatic logic entry_hits(input bp_pkg::bp_addr_t addr);
        bp_pkg::btb_entry_t e;
        e = model_btb[index_of(addr)];
        return e.busy && (e.tag == tag_of(addr));
    endfunction

    function automatic logic predicts_taken(input bp_pkg::bp_addr_t addr);
        return entry_hits(addr) &&
               (model_btb[index_of(addr)].state inside {bp_pkg::weak_taken, bp_pkg::taken});
    endfunction

    function automatic bp_pkg::bp_counter_e saturate(input bp_pkg::bp_counter_e cur,
                                                     input logic outcome);
        logic [1:0] v;
        v = cur;
        if (outcome && v != 2'b11) begin
            v = v + 2'd1;
        end else if (!outcome && v != 2'b00) begin
            v = v - 2'd1;
        end
        return bp_pkg::bp_counter_e'(v);
    endfunction

    // advance model by one cycle and fill in the row's expectation
    function automatic row_t model_step(input row_t r);
        bp_pkg::bp_addr_t    nxt;
        bp_pkg::bp_counter_e old_state;
        logic                mis;
        logic                al_hit;
        logic                tr_hit;
        int                  ai;
        int                  ti;
        mis = r.resolve.valid &&
              ((r.resolve.taken != r.resolve.pred_taken) ||
               (r.resolve.taken && (r.resolve.target != r.resolve.pred_target)));
        if (mis) begin
            nxt = r.resolve.taken ? r.resolve.target : r.resolve.pc + `BP_INST_BYTES;
        end else if (r.stall) begin
            nxt = model_pc;
        end else if (predicts_taken(model_pc)) begin
            nxt = model_btb[index_of(model_pc)].target_pc;
        end else begin
            nxt = model_pc + `BP_INST_BYTES;
        end
        // writes see the table as it was before this cycle
        ai        = index_of(r.decode.pc);
        ti        = index_of(r.resolve.pc);
        al_hit    = entry_hits(r.decode.pc);
        tr_hit    = entry_hits(r.resolve.pc);
        old_state = model_btb[ti].state;
        if (r.decode.valid && !al_hit) begin
            model_btb[ai].busy      = 1'b1;
            model_btb[ai].tag       = tag_of(r.decode.pc);
            model_btb[ai].target_pc = '0;
            model_btb[ai].state     = bp_pkg::nottake;
        end
        if (r.resolve.valid && tr_hit) begin  // train lands last
            model_btb[ti].target_pc = r.resolve.target;
            model_btb[ti].state     = saturate(old_state, r.resolve.taken);
        end
        model_pc     = nxt;
        r.exp_pc     = nxt;
        r.exp_taken  = predicts_taken(nxt);
        r.exp_target = r.exp_taken ? model_btb[index_of(nxt)].target_pc : nxt + `BP_INST_BYTES;
        return r;
    endfunction

    task automatic run_model();
        // fetch has stepped once past the reset vector when row 0 is driven
        model_pc = `BP_RESET_PC + `BP_INST_BYTES;
        foreach (model_btb[i]) begin
            model_btb[i] = '0;  // not busy, nottake
        end
        foreach (rows[i]) begin
            rows[i] = model_step(rows[i]);
        end
    endtask

    ////////////////////
    // stimulus table
    ////////////////////

    function automatic bp_pkg::bp_decode_t make_decode(input bp_pkg::bp_addr_t pc);
        bp_pkg::bp_decode_t d;
        d.valid = 1'b1;
        d.pc    = pc;
        return d;
    endfunction

    function automatic bp_pkg::bp_resolve_t make_resolve(input bp_pkg::bp_addr_t pc,
        input logic taken, input bp_pkg::bp_addr_t target,
        input logic pred_taken, input bp_pkg::bp_addr_t pred_target);
        bp_pkg::bp_resolve_t r;
        r.valid       = 1'b1;
        r.pc          = pc;
        r.taken       = taken;
        r.target      = target;
        r.pred_taken  = pred_taken;
        r.pred_target = pred_target;
        return r;
    endfunction

    // mispredicted taken branch from an unused pc, fetch lands on dest
    function automatic bp_pkg::bp_resolve_t steer_to(input bp_pkg::bp_addr_t dest);
        return make_resolve(STEER_PC, 1'b1, dest, 1'b0, '0);
    endfunction

    function automatic bp_pkg::bp_addr_t random_pc();
        return ($urandom & 32'h000f_fffc) | 32'h0010_0000;
    endfunction

    task automatic add_row(input int test, input logic stall_bit,
                           input bp_pkg::bp_decode_t d, input bp_pkg::bp_resolve_t r);
        row_t row;
        row         = '0;
        row.test    = test;
        row.stall   = stall_bit;
        row.decode  = d;
        row.resolve = r;
        rows.push_back(row);
    endtask

    task automatic add_idle(input int test, input logic stall_bit, input int count);
        repeat (count) add_row(test, stall_bit, '0, '0);
    endtask

    task automatic build_table();
        bp_pkg::bp_addr_t    cf_pc;
        bp_pkg::bp_addr_t    seq_pc;
        bp_pkg::bp_addr_t    hold_pc;
        bp_pkg::bp_resolve_t br_tk;
        bp_pkg::bp_resolve_t br_nt;
        bp_pkg::bp_resolve_t cf_tk;
        seq_pc  = random_pc();
        hold_pc = random_pc();
        cf_pc   = ($urandom & ~LOW_MASK) | (BR_PC & IDX_MASK);  // same index as BR_PC
        if (tag_of(cf_pc) == tag_of(BR_PC)) begin
            cf_pc = cf_pc ^ 32'h0100_0000;
        end
        br_tk = make_resolve(BR_PC, 1'b1, BR_TGT, 1'b1, BR_TGT);
        br_nt = make_resolve(BR_PC, 1'b0, BR_TGT, 1'b0, BR_PC + `BP_INST_BYTES);
        cf_tk = make_resolve(cf_pc, 1'b1, CF_TGT, 1'b1, CF_TGT);

        add_idle(1, 1'b0, 4);
        add_row(1, 1'b0, '0, steer_to(seq_pc));
        add_idle(1, 1'b0, 3);

        // counter up to weak_taken, then taken, then back down
        add_row(2, 1'b0, make_decode(BR_PC), '0);
        repeat (2) add_row(2, 1'b0, '0, br_tk);
        add_row(2, 1'b0, '0, steer_to(BR_PC));
        add_idle(2, 1'b0, 1);
        add_row(2, 1'b0, '0, br_tk);
        add_row(2, 1'b0, '0, br_nt);
        add_row(2, 1'b0, '0, steer_to(BR_PC));  // still taken after one nt
        add_idle(2, 1'b0, 1);
        repeat (2) add_row(2, 1'b0, '0, br_nt);
        add_row(2, 1'b0, '0, steer_to(BR_PC));
        add_idle(2, 1'b0, 1);

        add_row(3, 1'b0, '0, make_resolve(MP_PC, 1'b1, MP_TGT, 1'b0, '0));
        add_row(3, 1'b0, '0, make_resolve(MP_PC, 1'b0, MP_TGT, 1'b1, MP_TGT));
        add_row(3, 1'b0, '0, make_resolve(MP_PC, 1'b1, MP_TGT, 1'b1, MP_TGT + 32'h8));
        add_row(3, 1'b0, '0, make_resolve(MP_PC, 1'b1, MP_TGT, 1'b1, MP_TGT));
        add_row(3, 1'b0, '0, make_resolve(MP_PC, 1'b0, MP_TGT, 1'b0, '0));
        add_idle(3, 1'b0, 1);

        // cf_pc evicts BR_PC
        repeat (2) add_row(4, 1'b0, '0, br_tk);
        add_row(4, 1'b0, make_decode(cf_pc), '0);
        add_row(4, 1'b0, '0, steer_to(BR_PC));
        repeat (2) add_row(4, 1'b0, '0, br_tk);
        add_row(4, 1'b0, '0, steer_to(cf_pc));
        repeat (2) add_row(4, 1'b0, '0, cf_tk);
        add_row(4, 1'b0, '0, steer_to(cf_pc));
        add_idle(4, 1'b0, 1);
        add_row(4, 1'b0, make_decode(BR_PC), cf_tk);  // same index, same cycle
        add_row(4, 1'b0, '0, steer_to(BR_PC));
        add_idle(4, 1'b0, 1);

        add_idle(5, 1'b1, 3);
        add_row(5, 1'b1, '0, steer_to(hold_pc));
        add_idle(5, 1'b1, 2);
        add_idle(5, 1'b0, 2);

        add_row(6, 1'b0, '0, make_resolve(NA_PC, 1'b1, NA_TGT, 1'b0, '0));
        repeat (2) add_row(6, 1'b0, '0, make_resolve(NA_PC, 1'b1, NA_TGT, 1'b1, NA_TGT));
        add_row(6, 1'b0, '0, steer_to(NA_PC));
        add_idle(6, 1'b0, 2);
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic check_addr(input string name, input bp_pkg::bp_addr_t got,
                              input bp_pkg::bp_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_fetch(input bp_pkg::bp_fetch_t got, input bp_pkg::bp_fetch_t exp,
                               input int row);
        string where;
        where = $sformatf(" (row %0d)", row);
        check_bit({"fetch.valid", where}, got.valid, exp.valid);
        check_addr({"fetch.pc", where}, got.pc, exp.pc);
        check_bit({"fetch.pred_taken", where}, got.pred_taken, exp.pred_taken);
        check_addr({"fetch.pred_target", where}, got.pred_target, exp.pred_target);
    endtask

    task automatic report_test(input int test);
        tests_run++;
        if (test_err == 0) begin
            $display("test %0d %s: pass", test, test_names[test]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", test, test_names[test], test_err);
        end
        test_err = 0;
    endtask

    task automatic check_row(input int idx);
        bp_pkg::bp_fetch_t exp;
        exp.valid       = 1'b1;
        exp.pc          = rows[idx].exp_pc;
        exp.pred_taken  = rows[idx].exp_taken;
        exp.pred_target = rows[idx].exp_target;
        check_fetch(fetch, exp, idx);
        if (idx == rows.size() - 1 || rows[idx + 1].test != rows[idx].test) begin
            report_test(rows[idx].test);
        end
    endtask

    task automatic wait_fetch_valid(input int limit, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < limit) begin
            @(negedge clock);
            if (fetch.valid === 1'b1) begin
                ok = 1'b1;
            end
            n++;
        end
    endtask

    ////////////////////
    // run
    ////////////////////

    initial begin
        logic ok;
        reset   <= 1'b1;
        stall   <= 1'b0;
        decode  <= '0;
        resolve <= '0;
        void'($urandom(32'h167c));
        test_names[1] = "reset and sequential fetch";
        test_names[2] = "allocate and train";
        test_names[3] = "mispredict redirect";
        test_names[4] = "tag conflict";
        test_names[5] = "stall";
        test_names[6] = "train without allocation";
        build_table();
        run_model();

        repeat (8) @(posedge clock);
        reset <= 1'b0;

        wait_fetch_valid(20, ok);
        if (!ok) begin
            $display("timeout: fetch.valid did not rise within 20 cycles after reset");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            check_addr("fetch.pc (after reset)", fetch.pc, `BP_RESET_PC);
            check_bit("fetch.pred_taken (after reset)", fetch.pred_taken, 1'b0);
            for (int i = 0; i <= rows.size(); i++) begin
                @(posedge clock);
                if (i < rows.size()) begin
                    stall   <= rows[i].stall;
                    decode  <= rows[i].decode;
                    resolve <= rows[i].resolve;
                end else begin
                    stall   <= 1'b0;
                    decode  <= '0;
                    resolve <= '0;
                end
                @(negedge clock);
                if (i > 0) begin
                    check_row(i - 1);  // previous row has taken effect
                end
            end
            $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                     tests_run, tests_failed, checks, errors);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+design
design/bp_pkg.sv
design/btb.sv
design/fetch_pc_gen.sv
design/branch_resolve.sv
design/branch_predict_top.sv
tb/branch_predict_tb.sv

// ==== Makefile ====
# tool, flags, top module and file list
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0 --Mdir obj_dir
TOP       := branch_predict_tb
FILE_LIST := list.f
PASS_MSG  := NO ERRORS

SIM := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
